/* hdl/drive_channel.sv */
/* One drive motor channel. Holds the writable control byte and
   samples the fault and temperature inputs into the status byte. */
`timescale 1ns/1ps

module drive_channel (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           wr,          // Control byte strobe
    input  motor_regs_pkg::reg_data_t      wr_data,
    input  motor_regs_pkg::drive_status_t  status_in,
    output motor_regs_pkg::drive_ctrl_t    ctrl,
    output motor_regs_pkg::drive_regs_t    regs         // Stored bytes for read-back
);
    import motor_regs_pkg::*;

    reg_data_t ctrl_q;
    reg_data_t status_q;

    // Control byte, one cycle after the write
    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl_q <= '0;
        end else if (wr) begin
            ctrl_q <= wr_data;
        end
    end

    // Status sampled every clock
    always_ff @(posedge clock) begin
        if (reset) begin
            status_q <= '0;
        end else begin
            status_q <= {status_in.fault, status_in.adc_temp};   // Fault in bit 7
        end
    end

    // Struct layout is the byte layout
    assign ctrl = drive_ctrl_t'(ctrl_q);

    assign regs.ctrl   = ctrl_q;
    assign regs.status = status_q;

endmodule

/* hdl/motor_reg_file.sv */
/* Top level of the swerve-drive motor register file. Byte-wide bus with
   plain read and write strobes, four drive and four rotation channels. */
`timescale 1ns/1ps

module motor_reg_file (
    input  logic                                                   clock,
    input  logic                                                   reset,
    input  motor_regs_pkg::reg_addr_t                              address,
    input  logic                                                   write_en,
    input  motor_regs_pkg::reg_data_t                              wr_data,
    input  logic                                                   read_en,
    output motor_regs_pkg::reg_data_t                              rd_data,

    // Drive motors
    input  motor_regs_pkg::drive_status_t [motor_regs_pkg::NUM_DRIVE-1:0] drive_status,
    output motor_regs_pkg::drive_ctrl_t   [motor_regs_pkg::NUM_DRIVE-1:0] drive_ctrl,

    // Rotation motors
    input  motor_regs_pkg::rot_status_t   [motor_regs_pkg::NUM_ROT-1:0]   rot_status,
    output motor_regs_pkg::rot_ctrl_t     [motor_regs_pkg::NUM_ROT-1:0]   rot_ctrl,
    output motor_regs_pkg::rot_cmd_t      [motor_regs_pkg::NUM_ROT-1:0]   rot_cmd
);
    import motor_regs_pkg::*;

    // Decoder strobes
    logic [NUM_DRIVE-1:0] drive_wr;
    logic [NUM_ROT-1:0]   rot_ctrl_wr;
    logic [NUM_ROT-1:0]   rot_targ_wr;
    logic [NUM_ROT-1:0]   rot_cmd_wr;

    // Stored bytes toward the read-back mux
    drive_regs_t [NUM_DRIVE-1:0] drive_regs;
    rot_regs_t   [NUM_ROT-1:0]   rot_regs;

    reg_decoder i_reg_decoder (
        .address     (address),
        .write_en    (write_en),
        .drive_wr    (drive_wr),
        .rot_ctrl_wr (rot_ctrl_wr),
        .rot_targ_wr (rot_targ_wr),
        .rot_cmd_wr  (rot_cmd_wr)
    );

    // Drive channels 0x04..0x0B
    for (genvar i = 0; i < NUM_DRIVE; i++) begin : g_drive
        drive_channel i_drive_channel (
            .clock     (clock),
            .reset     (reset),
            .wr        (drive_wr[i]),
            .wr_data   (wr_data),
            .status_in (drive_status[i]),
            .ctrl      (drive_ctrl[i]),
            .regs      (drive_regs[i])
        );
    end

    // Rotation channels 0x0C..0x1F
    for (genvar i = 0; i < NUM_ROT; i++) begin : g_rot
        rotation_channel i_rotation_channel (
            .clock     (clock),
            .reset     (reset),
            .ctrl_wr   (rot_ctrl_wr[i]),
            .targ_wr   (rot_targ_wr[i]),
            .cmd_wr    (rot_cmd_wr[i]),
            .wr_data   (wr_data),
            .status_in (rot_status[i]),
            .ctrl      (rot_ctrl[i]),
            .cmd       (rot_cmd[i]),
            .regs      (rot_regs[i])
        );
    end

    readback_mux i_readback_mux (
        .clock      (clock),
        .reset      (reset),
        .address    (address),
        .read_en    (read_en),
        .drive_regs (drive_regs),
        .rot_regs   (rot_regs),
        .rd_data    (rd_data)
    );

endmodule

/* hdl/motor_regs_pkg.sv */
/* Widths, address map and packed types shared by the motor register file.
   Every RTL module imports what it needs from here. */
package motor_regs_pkg;

    // Widths
    localparam int ADDR_W     = 6;
    localparam int REG_W      = 8;
    localparam int ANGLE_W    = 12;
    localparam int ANGLE_HI_W = ANGLE_W - REG_W;    // Angle bits held in the control byte
    localparam int ADC_TEMP_W = 7;
    localparam int ROT_TEMP_W = 6;                  // Rotation status keeps only 6 bits
    localparam int PWM_W      = 5;

    typedef logic [ADDR_W-1:0]     reg_addr_t;
    typedef logic [REG_W-1:0]      reg_data_t;
    typedef logic [ANGLE_W-1:0]    angle_t;
    typedef logic [ADC_TEMP_W-1:0] adc_temp_t;
    typedef logic [PWM_W-1:0]      pwm_t;

    localparam int NUM_DRIVE = 4;
    localparam int NUM_ROT   = 4;

    // Fixed addresses
    localparam reg_addr_t ADDR_RESERVED    = 6'h00;   // Writes dropped
    localparam reg_addr_t ADDR_BCAST_ALL   = 6'h01;   // All eight control regs
    localparam reg_addr_t ADDR_BCAST_ROT   = 6'h02;   // Rotation control regs only
    localparam reg_addr_t ADDR_BCAST_DRIVE = 6'h03;   // Drive control regs only

    // Drive blocks start at 0x04, two bytes each
    localparam int DRIVE_BASE       = 'h04;
    localparam int DRIVE_STRIDE     = 2;
    localparam int DRIVE_CTRL_OFS   = 0;
    localparam int DRIVE_STATUS_OFS = 1;

    // Rotation blocks start at 0x0C, five bytes each
    localparam int ROT_BASE        = 'h0C;
    localparam int ROT_STRIDE      = 5;
    localparam int ROT_CTRL_OFS    = 0;
    localparam int ROT_STATUS_OFS  = 1;
    localparam int ROT_TARG_OFS    = 2;
    localparam int ROT_CURR_LO_OFS = 3;
    localparam int ROT_CURR_HI_OFS = 4;   // Also the command address

    // Control byte bits shared by both channel kinds
    localparam int CTRL_BRAKE_BIT  = 7;
    localparam int CTRL_ENABLE_BIT = 6;
    localparam int CTRL_DIR_BIT    = 5;

    // Command bits written to the current-high address
    localparam int CMD_UPDATE_BIT = 5;
    localparam int CMD_ABORT_BIT  = 4;

    // Field order matches the control byte, MSB first
    typedef struct packed {
        logic brake;
        logic enable;
        logic direction;
        pwm_t pwm;
    } drive_ctrl_t;

    typedef struct packed {
        logic      fault;
        adc_temp_t adc_temp;
    } drive_status_t;

    typedef struct packed {
        logic   brake;
        logic   enable;
        logic   direction;
        angle_t target_angle;
    } rot_ctrl_t;

    typedef struct packed {
        logic      fault;
        logic      startup_fail;
        adc_temp_t adc_temp;         // Low 6 bits used
        angle_t    current_angle;
        logic      angle_done;
    } rot_status_t;

    typedef struct packed {
        logic update;
        logic abort;
    } rot_cmd_t;

    // Stored bytes of each channel, as seen by the read-back path
    typedef struct packed {
        reg_data_t ctrl;
        reg_data_t status;
    } drive_regs_t;

    typedef struct packed {
        reg_data_t ctrl;
        reg_data_t status;
        reg_data_t targ;
        reg_data_t curr_lo;
        reg_data_t curr_hi;
    } rot_regs_t;

    // Byte address of one register in a drive block
    function automatic reg_addr_t drive_addr(input int ch, input int ofs);
        return reg_addr_t'(DRIVE_BASE + DRIVE_STRIDE * ch + ofs);
    endfunction

    // Byte address of one register in a rotation block
    function automatic reg_addr_t rot_addr(input int ch, input int ofs);
        return reg_addr_t'(ROT_BASE + ROT_STRIDE * ch + ofs);
    endfunction

endpackage

/* hdl/readback_mux.sv */
/* Read-back path. Picks the addressed byte from the channel registers
   and loads it into rd_data on read_en. Unmapped addresses read 0. */
`timescale 1ns/1ps

module readback_mux (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  motor_regs_pkg::reg_addr_t                            address,
    input  logic                                                 read_en,
    input  motor_regs_pkg::drive_regs_t [motor_regs_pkg::NUM_DRIVE-1:0] drive_regs,
    input  motor_regs_pkg::rot_regs_t   [motor_regs_pkg::NUM_ROT-1:0]   rot_regs,
    output motor_regs_pkg::reg_data_t                            rd_data
);
    import motor_regs_pkg::*;

    reg_data_t sel_byte;

    // Address to byte, zero when nothing matches
    always_comb begin
        sel_byte = '0;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            if (address == drive_addr(i, DRIVE_CTRL_OFS)) begin
                sel_byte = drive_regs[i].ctrl;
            end
            if (address == drive_addr(i, DRIVE_STATUS_OFS)) begin
                sel_byte = drive_regs[i].status;
            end
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            if (address == rot_addr(i, ROT_CTRL_OFS)) begin
                sel_byte = rot_regs[i].ctrl;
            end
            if (address == rot_addr(i, ROT_STATUS_OFS)) begin
                sel_byte = rot_regs[i].status;
            end
            if (address == rot_addr(i, ROT_TARG_OFS)) begin
                sel_byte = rot_regs[i].targ;
            end
            if (address == rot_addr(i, ROT_CURR_LO_OFS)) begin
                sel_byte = rot_regs[i].curr_lo;
            end
            if (address == rot_addr(i, ROT_CURR_HI_OFS)) begin
                sel_byte = rot_regs[i].curr_hi;
            end
        end
    end

    // Holds between reads
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= sel_byte;
        end
    end

endmodule

/* hdl/reg_decoder.sv */
/* Write address decoder. Turns address plus write_en into one strobe
   per writable register, with the broadcast groups folded into the control strobes. */
`timescale 1ns/1ps

module reg_decoder (
    input  motor_regs_pkg::reg_addr_t             address,
    input  logic                                  write_en,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]  drive_wr,      // Drive control strobes
    output logic [motor_regs_pkg::NUM_ROT-1:0]    rot_ctrl_wr,   // Rotation control strobes
    output logic [motor_regs_pkg::NUM_ROT-1:0]    rot_targ_wr,   // Target low byte strobes
    output logic [motor_regs_pkg::NUM_ROT-1:0]    rot_cmd_wr     // Update/abort command strobes
);
    import motor_regs_pkg::*;

    logic wr_ok;
    logic bcast_drive;
    logic bcast_rot;

    // Reserved address never reaches a register
    assign wr_ok = write_en && (address != ADDR_RESERVED);

    // Broadcast groups
    assign bcast_drive = (address == ADDR_BCAST_ALL) || (address == ADDR_BCAST_DRIVE);
    assign bcast_rot   = (address == ADDR_BCAST_ALL) || (address == ADDR_BCAST_ROT);

    always_comb begin
        drive_wr    = '0;
        rot_ctrl_wr = '0;
        rot_targ_wr = '0;
        rot_cmd_wr  = '0;

        // Drive blocks 0x04..0x0B
        for (int i = 0; i < NUM_DRIVE; i++) begin
            drive_wr[i] = wr_ok &&
                          (bcast_drive || (address == drive_addr(i, DRIVE_CTRL_OFS)));
        end

        // Rotation blocks 0x0C..0x1F
        for (int i = 0; i < NUM_ROT; i++) begin
            rot_ctrl_wr[i] = wr_ok &&
                             (bcast_rot || (address == rot_addr(i, ROT_CTRL_OFS)));
            rot_targ_wr[i] = wr_ok && (address == rot_addr(i, ROT_TARG_OFS));   // No broadcast
            rot_cmd_wr[i]  = wr_ok && (address == rot_addr(i, ROT_CURR_HI_OFS));
        end
    end

endmodule

/* hdl/rotation_channel.sv */
/* One swerve rotation motor channel. Control and target-angle bytes,
   sampled status and current-angle bytes, plus one-cycle update and abort pulses. */
`timescale 1ns/1ps

module rotation_channel (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          ctrl_wr,     // Control byte strobe
    input  logic                          targ_wr,     // Target low byte strobe
    input  logic                          cmd_wr,      // Write to current-high address
    input  motor_regs_pkg::reg_data_t     wr_data,
    input  motor_regs_pkg::rot_status_t   status_in,
    output motor_regs_pkg::rot_ctrl_t     ctrl,
    output motor_regs_pkg::rot_cmd_t      cmd,
    output motor_regs_pkg::rot_regs_t     regs         // Stored bytes for read-back
);
    import motor_regs_pkg::*;

    reg_data_t ctrl_q;      // Full byte kept so it reads back as written
    reg_data_t targ_q;
    reg_data_t status_q;
    reg_data_t curr_lo_q;
    reg_data_t curr_hi_q;
    rot_cmd_t  cmd_q;

    // Writable bytes
    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl_q <= '0;
            targ_q <= '0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= wr_data;
            end
            if (targ_wr) begin
                targ_q <= wr_data;
            end
        end
    end

    // Status and current angle sampled every clock
    always_ff @(posedge clock) begin
        if (reset) begin
            status_q  <= '0;
            curr_lo_q <= '0;
            curr_hi_q <= '0;
        end else begin
            status_q  <= {status_in.fault, status_in.startup_fail,
                          status_in.adc_temp[ROT_TEMP_W-1:0]};
            curr_lo_q <= status_in.current_angle[REG_W-1:0];
            curr_hi_q <= {status_in.angle_done,
                          {(REG_W - 1 - ANGLE_HI_W){1'b0}},          // Bits 6:4 read as 0
                          status_in.current_angle[ANGLE_W-1:REG_W]};
        end
    end

    // Command pulses last one cycle since they reload every clock
    always_ff @(posedge clock) begin
        if (reset) begin
            cmd_q <= '0;
        end else begin
            cmd_q.update <= cmd_wr && wr_data[CMD_UPDATE_BIT];
            cmd_q.abort  <= cmd_wr && wr_data[CMD_ABORT_BIT];
        end
    end

    assign ctrl.brake        = ctrl_q[CTRL_BRAKE_BIT];
    assign ctrl.enable       = ctrl_q[CTRL_ENABLE_BIT];
    assign ctrl.direction    = ctrl_q[CTRL_DIR_BIT];
    assign ctrl.target_angle = {ctrl_q[ANGLE_HI_W-1:0], targ_q};   // Bit 4 unused
    assign cmd               = cmd_q;

    assign regs.ctrl    = ctrl_q;
    assign regs.status  = status_q;
    assign regs.targ    = targ_q;
    assign regs.curr_lo = curr_lo_q;
    assign regs.curr_hi = curr_hi_q;

endmodule

/* list.f */
hdl/motor_regs_pkg.sv
hdl/reg_decoder.sv
hdl/drive_channel.sv
hdl/rotation_channel.sv
hdl/readback_mux.sv
hdl/motor_reg_file.sv
verif/motor_reg_file_tb.sv

/* run.sh */
#!/bin/sh
# Builds the motor register file testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module motor_reg_file_tb -o motor_reg_file_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/motor_reg_file_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

/* verif/motor_reg_file_tb.sv */
/* Table-driven testbench for the motor register file. Rows of writes, reads,
   status updates and pulse checks run in a loop against a local model of every register. */
`timescale 1ns/1ps

module motor_reg_file_tb;
    import motor_regs_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 10002;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_STATUS, OP_PULSE} op_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t addr;
        reg_data_t data;         // Write data or command bits
        logic      from_model;   // Read expects the model byte
        reg_data_t expected;     // Fixed read value otherwise
    } row_t;

    logic      clock = 1'b0;
    logic      reset;
    reg_addr_t address;
    logic      write_en;
    reg_data_t wr_data;
    logic      read_en;
    reg_data_t rd_data;

    drive_status_t [NUM_DRIVE-1:0] drive_status;
    drive_ctrl_t   [NUM_DRIVE-1:0] drive_ctrl;
    rot_status_t   [NUM_ROT-1:0]   rot_status;
    rot_ctrl_t     [NUM_ROT-1:0]   rot_ctrl;
    rot_cmd_t      [NUM_ROT-1:0]   rot_cmd;

    // Reference model
    reg_data_t                     drive_ctrl_m [NUM_DRIVE];
    reg_data_t                     rot_ctrl_m   [NUM_ROT];
    reg_data_t                     rot_targ_m   [NUM_ROT];
    drive_status_t [NUM_DRIVE-1:0] drive_status_m;   // Values driven on the inputs
    rot_status_t   [NUM_ROT-1:0]   rot_status_m;

    row_t rows[$];
    int   num_rows = 0;

    always #(CLK_PERIOD / 2) clock = ~clock;

    motor_reg_file i_motor_reg_file (
        .clock        (clock),
        .reset        (reset),
        .address      (address),
        .write_en     (write_en),
        .wr_data      (wr_data),
        .read_en      (read_en),
        .rd_data      (rd_data),
        .drive_status (drive_status),
        .drive_ctrl   (drive_ctrl),
        .rot_status   (rot_status),
        .rot_ctrl     (rot_ctrl),
        .rot_cmd      (rot_cmd)
    );

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic add_row(input op_t op, input int a, input int d, input logic from_model,
                           input int exp_val);
        row_t r;
        r.op         = op;
        r.addr       = reg_addr_t'(a);
        r.data       = reg_data_t'(d);
        r.from_model = from_model;
        r.expected   = reg_data_t'(exp_val);
        rows.push_back(r);
    endtask

    // Reads of every control and target byte, checked against the model
    task automatic add_ctrl_reads();
        for (int i = 0; i < NUM_DRIVE; i++) begin
            add_row(OP_READ, DRIVE_BASE + DRIVE_STRIDE * i, 0, 1'b1, 0);
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            add_row(OP_READ, ROT_BASE + ROT_STRIDE * i, 0, 1'b1, 0);
            add_row(OP_READ, ROT_BASE + ROT_STRIDE * i + 2, 0, 1'b1, 0);
        end
    endtask

    // Write side of the address map, broadcasts included
    function automatic void model_write(input reg_addr_t a, input reg_data_t d);
        int n;
        int ch;
        int ofs;
        n = int'(a);
        for (int i = 0; i < NUM_DRIVE; i++) begin
            if (n == 1 || n == 3) drive_ctrl_m[i] = d;
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            if (n == 1 || n == 2) rot_ctrl_m[i] = d;
        end
        if (n >= DRIVE_BASE && n < DRIVE_BASE + NUM_DRIVE * DRIVE_STRIDE) begin
            ch  = (n - DRIVE_BASE) / DRIVE_STRIDE;
            ofs = (n - DRIVE_BASE) % DRIVE_STRIDE;
            if (ofs == 0) drive_ctrl_m[ch] = d;
        end else if (n >= ROT_BASE && n < ROT_BASE + NUM_ROT * ROT_STRIDE) begin
            ch  = (n - ROT_BASE) / ROT_STRIDE;
            ofs = (n - ROT_BASE) % ROT_STRIDE;
            if (ofs == 0) rot_ctrl_m[ch] = d;
            if (ofs == 2) rot_targ_m[ch] = d;   // Offset 4 is a command, stores nothing
        end
    endfunction

    // Expected read-back byte for any address
    function automatic reg_data_t model_byte(input reg_addr_t a);
        int        n;
        int        ch;
        int        ofs;
        reg_data_t b;
        n = int'(a);
        b = '0;   // Unmapped and broadcast addresses
        if (n >= DRIVE_BASE && n < DRIVE_BASE + NUM_DRIVE * DRIVE_STRIDE) begin
            ch  = (n - DRIVE_BASE) / DRIVE_STRIDE;
            ofs = (n - DRIVE_BASE) % DRIVE_STRIDE;
            if (ofs == 0) b = drive_ctrl_m[ch];
            else          b = {drive_status_m[ch].fault, drive_status_m[ch].adc_temp};
        end else if (n >= ROT_BASE && n < ROT_BASE + NUM_ROT * ROT_STRIDE) begin
            ch  = (n - ROT_BASE) / ROT_STRIDE;
            ofs = (n - ROT_BASE) % ROT_STRIDE;
            case (ofs)
                0:       b = rot_ctrl_m[ch];
                1:       b = {rot_status_m[ch].fault, rot_status_m[ch].startup_fail,
                              rot_status_m[ch].adc_temp[5:0]};
                2:       b = rot_targ_m[ch];
                3:       b = rot_status_m[ch].current_angle[7:0];
                default: b = {rot_status_m[ch].angle_done, 3'b000,
                              rot_status_m[ch].current_angle[11:8]};
            endcase
        end
        return b;
    endfunction

    task automatic check_outputs();
        reg_data_t m;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            m = drive_ctrl_m[i];
            assert ({drive_ctrl[i].brake, drive_ctrl[i].enable, drive_ctrl[i].direction,
                     drive_ctrl[i].pwm} == {m[7], m[6], m[5], m[4:0]})
            else report_error($sformatf("drive %0d ctrl %h, expected byte %h",
                                        i, drive_ctrl[i], m));
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            m = rot_ctrl_m[i];
            // Angle is control bits 3:0 then the target low byte
            assert ({rot_ctrl[i].brake, rot_ctrl[i].enable, rot_ctrl[i].direction,
                     rot_ctrl[i].target_angle} == {m[7], m[6], m[5], m[3:0], rot_targ_m[i]})
            else report_error($sformatf("rotation %0d ctrl %h, expected byte %h targ %h",
                                        i, rot_ctrl[i], m, rot_targ_m[i]));
        end
    endtask

    // Channel ch may pulse, every other channel stays low
    task automatic check_pulses(input int ch, input logic upd, input logic abt);
        logic exp_u;
        logic exp_a;
        for (int i = 0; i < NUM_ROT; i++) begin
            exp_u = (i == ch) && upd;
            exp_a = (i == ch) && abt;
            assert (rot_cmd[i].update == exp_u && rot_cmd[i].abort == exp_a)
            else report_error($sformatf("rotation %0d cmd %b, expected %b",
                                        i, rot_cmd[i], {exp_u, exp_a}));
        end
    endtask

    task automatic draw_status();
        logic [31:0] r;
        for (int i = 0; i < NUM_DRIVE; i++) begin
            r = $urandom;
            drive_status_m[i].fault    = r[7];
            drive_status_m[i].adc_temp = r[6:0];
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            r = $urandom;
            rot_status_m[i].fault         = r[0];
            rot_status_m[i].startup_fail  = r[1];
            rot_status_m[i].adc_temp      = r[8:2];
            rot_status_m[i].current_angle = r[20:9];
            rot_status_m[i].angle_done    = r[21];
        end
        @(posedge clock);
        drive_status <= drive_status_m;
        rot_status   <= rot_status_m;
        repeat (2) @(posedge clock);   // Held two cycles before any read
    endtask

    task automatic apply_row(input row_t r);
        reg_data_t want;
        int        ch;
        case (r.op)
            OP_WRITE: begin
                @(posedge clock);
                address  <= r.addr;
                write_en <= 1'b1;
                wr_data  <= r.data;
                @(posedge clock);                  // Write sampled here
                write_en <= 1'b0;
                model_write(r.addr, r.data);
                @(negedge clock);
                check_outputs();
                check_pulses(-1, 1'b0, 1'b0);      // Plain writes raise no pulse
            end
            OP_READ: begin
                want = r.from_model ? model_byte(r.addr) : r.expected;
                @(posedge clock);
                address <= r.addr;
                read_en <= 1'b1;
                @(posedge clock);                  // rd_data loads here
                read_en <= 1'b0;
                @(negedge clock);
                assert (rd_data == want)
                else report_error($sformatf("read of %h gave %h, expected %h",
                                            r.addr, rd_data, want));
            end
            OP_STATUS: draw_status();
            OP_PULSE: begin
                ch = (int'(r.addr) - ROT_BASE) / ROT_STRIDE;
                @(posedge clock);
                address  <= r.addr;
                write_en <= 1'b1;
                wr_data  <= r.data;
                @(negedge clock);
                check_pulses(-1, 1'b0, 1'b0);      // Not before the sampling edge
                @(posedge clock);
                write_en <= 1'b0;
                @(negedge clock);
                check_pulses(ch, r.data[CMD_UPDATE_BIT], r.data[CMD_ABORT_BIT]);
                @(posedge clock);
                @(negedge clock);
                check_pulses(-1, 1'b0, 1'b0);      // Gone after one cycle
                check_outputs();                   // Command write stores nothing
            end
            default: report_error("unknown operation in the test table");
        endcase
    endtask

    task automatic build_table();
        // Reset values of control and target bytes
        for (int i = 0; i < NUM_DRIVE; i++) begin
            add_row(OP_READ, DRIVE_BASE + DRIVE_STRIDE * i, 0, 1'b0, 0);
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            add_row(OP_READ, ROT_BASE + ROT_STRIDE * i, 0, 1'b0, 0);
            add_row(OP_READ, ROT_BASE + ROT_STRIDE * i + 2, 0, 1'b0, 0);
        end
        // One channel at a time
        for (int i = 0; i < NUM_DRIVE; i++) begin
            add_row(OP_WRITE, DRIVE_BASE + DRIVE_STRIDE * i, 'h21 + 'h3B * i, 1'b0, 0);
            add_row(OP_READ, DRIVE_BASE + DRIVE_STRIDE * i, 0, 1'b1, 0);
        end
        for (int i = 0; i < NUM_ROT; i++) begin
            add_row(OP_WRITE, ROT_BASE + ROT_STRIDE * i, 'hC3 ^ (i << 2), 1'b0, 0);
            add_row(OP_WRITE, ROT_BASE + ROT_STRIDE * i + 2, 'h5C + 'h27 * i, 1'b0, 0);
            add_row(OP_READ, ROT_BASE + ROT_STRIDE * i, 0, 1'b1, 0);
            add_row(OP_READ, ROT_BASE + ROT_STRIDE * i + 2, 0, 1'b1, 0);
        end
        // Broadcast groups
        add_row(OP_WRITE, 'h01, 'hE7, 1'b0, 0);
        add_ctrl_reads();
        add_row(OP_WRITE, 'h02, 'h5A, 1'b0, 0);
        add_ctrl_reads();
        add_row(OP_WRITE, 'h03, 'h93, 1'b0, 0);
        add_ctrl_reads();
        // Random status inputs, twice
        for (int k = 0; k < 2; k++) begin
            add_row(OP_STATUS, 0, 0, 1'b0, 0);
            for (int i = 0; i < NUM_DRIVE; i++) begin
                add_row(OP_READ, DRIVE_BASE + DRIVE_STRIDE * i + 1, 0, 1'b1, 0);
            end
            for (int i = 0; i < NUM_ROT; i++) begin
                add_row(OP_READ, ROT_BASE + ROT_STRIDE * i + 1, 0, 1'b1, 0);
                add_row(OP_READ, ROT_BASE + ROT_STRIDE * i + 3, 0, 1'b1, 0);
                add_row(OP_READ, ROT_BASE + ROT_STRIDE * i + 4, 0, 1'b1, 0);
            end
        end
        // Update and abort pulses
        for (int i = 0; i < NUM_ROT; i++) begin
            add_row(OP_PULSE, ROT_BASE + ROT_STRIDE * i + 4, 'h20, 1'b0, 0);
            add_row(OP_PULSE, ROT_BASE + ROT_STRIDE * i + 4, 'h10, 1'b0, 0);
        end
        add_row(OP_PULSE, ROT_BASE + ROT_STRIDE * 2 + 4, 'h30, 1'b0, 0);   // Both at once
        add_row(OP_PULSE, ROT_BASE + ROT_STRIDE * 1 + 4, 'hCF, 1'b0, 0);   // No command bit
        // Reserved and unmapped addresses
        add_row(OP_WRITE, 'h00, 'hFF, 1'b0, 0);
        add_ctrl_reads();
        for (int a = 0; a < 4; a++) add_row(OP_READ, a, 0, 1'b0, 0);
        add_row(OP_READ, 'h20, 0, 1'b0, 0);
        add_row(OP_READ, 'h21, 0, 1'b0, 0);
        add_row(OP_READ, 'h3F, 0, 1'b0, 0);
    endtask

    // Watchdog sized from the table, 4 clocks per row
    initial begin
        wait (num_rows != 0);
        #((num_rows * 4 + RESET_CYCLES + 8) * CLK_PERIOD);
        $display("Timeout after %0d table rows, the test did not finish", num_rows);
        $display("Test FAILED");
        $fatal(1, "Simulation timed out");
    end

    initial begin
        void'($urandom(SEED));
        reset          = 1'b1;
        address        = '0;
        write_en       = 1'b0;
        wr_data        = '0;
        read_en        = 1'b0;
        drive_status   = '0;
        rot_status     = '0;
        drive_status_m = '0;
        rot_status_m   = '0;
        foreach (drive_ctrl_m[i]) drive_ctrl_m[i] = '0;
        foreach (rot_ctrl_m[i]) rot_ctrl_m[i] = '0;
        foreach (rot_targ_m[i]) rot_targ_m[i] = '0;
        build_table();
        num_rows = rows.size();
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_outputs();                 // All control outputs cleared
        check_pulses(-1, 1'b0, 1'b0);
        foreach (rows[k]) apply_row(rows[k]);
        $display("Test OK");
        $finish;
    end

endmodule
